// ==== build.f ====
src/cpuControlPkg.sv
src/instrDecoder.sv
src/phaseSequencer.sv
src/controlEncoder.sv
src/multicycleControl.sv
sim/multicycleControl_properties.sv
sim/tb_multicycleControl.sv

// ==== Bender.yml ====
package:
  name: multicycle_control

sources:
  # package first, then leaf modules, then the top level
  - src/cpuControlPkg.sv
  - src/instrDecoder.sv
  - src/phaseSequencer.sv
  - src/controlEncoder.sv
  - src/multicycleControl.sv

  - target: simulation
    files:
      - sim/multicycleControl_properties.sv
      - sim/tb_multicycleControl.sv

// ==== sim/control_trace.txt ====
# name opcode(hex) func(hex) execAluOp(dec) regDst(rt|rd|link|none) irWriteSpacing event
# spacing is in cycles for MemLatency 2; event is none, wwd, illegal or halt
add    f 00 0  rd   5 none
sub    f 01 1  rd   5 none
and    f 02 2  rd   5 none
orr    f 03 3  rd   5 none
not    f 04 4  rd   5 none
tcp    f 05 5  rd   5 none
shl    f 06 6  rd   5 none
shr    f 07 7  rd   5 none
adi    4 00 0  rt   5 none
ori    5 00 3  rt   5 none
lhi    6 00 8  rt   5 none
lwd    7 00 0  rt   7 none
swd    8 00 0  none 6 none
bne    0 00 9  none 4 none
beq    1 00 10 none 4 none
bgz    2 00 11 none 4 none
blz    3 00 12 none 4 none
jmp    9 00 0  none 4 none
jal    a 00 0  link 5 none
jpr    f 19 0  none 4 none
jrl    f 1a 0  link 5 none
wwd    f 1c 0  none 4 wwd
badOp  b 00 0  none 4 illegal
badFn  f 08 0  none 4 illegal
hlt    f 1d 0  none 0 halt

// ==== sim/tb_multicycleControl.sv ====
`timescale 1ns/1ps

module tb_multicycleControl;

    localparam int MemLatency = 2;
    localparam int HaltWatch  = 20;    // idle cycles watched after halt

    logic                    clk;
    logic                    arstN;
    cpuControlPkg::opcode_t  opcode;
    cpuControlPkg::func_t    func;
    logic                    pcWrite;
    logic                    pcWriteCond;
    logic                    iorD;
    logic                    memRead;
    logic                    memWrite;
    logic                    irWrite;
    logic                    mdrWrite;
    logic                    memToReg;
    logic                    regWrite;
    logic                    wwdValid;
    logic                    illegalInstr;
    logic                    halted;
    cpuControlPkg::pcSel_t   pcSource;
    cpuControlPkg::aluFunc_t aluOp;
    cpuControlPkg::aSel_t    aluSrcA;
    cpuControlPkg::bSel_t    aluSrcB;
    cpuControlPkg::immKind_t immSel;
    cpuControlPkg::regDst_t  regDstSel;
    logic [24:0]             ctlBits;

    string names[$];
    int    opCodes[$];
    int    funcCodes[$];
    int    aluOps[$];
    int    dsts[$];
    int    spacings[$];
    string events[$];
    bit    traceLoaded = 1'b0;

    assign ctlBits = {pcWrite, pcWriteCond, iorD, memRead, memWrite, irWrite, mdrWrite,
                      memToReg, regWrite, wwdValid, illegalInstr, halted,
                      pcSource, aluOp, aluSrcA, aluSrcB, immSel, regDstSel};

    multicycleControl #(
        .MemLatency (MemLatency)
    ) DUT (.*);

    task automatic failRun(input string reason);
        $display("%s", reason);
        $display("=== FAIL ===");
        $fatal(1, "run stopped");
    endtask

    task automatic checkValue(input string testName, input string what,
                              input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected)
            failRun($sformatf("** Error %s %s: expected %0h, actual %0h",
                              testName, what, expected, actual));
    endtask

    function automatic int dstCode(input string s);
        if (s == "rt")
            return cpuControlPkg::DstRt;
        if (s == "rd")
            return cpuControlPkg::DstRd;
        if (s == "link")
            return cpuControlPkg::DstLink;
        return -1;    // no register write
    endfunction

    task automatic loadTrace();
        int    fd;
        int    n;
        int    op;
        int    fn;
        int    alu;
        int    sp;
        string line;
        string nm;
        string dst;
        string ev;
        fd = $fopen("sim/control_trace.txt", "r");
        if (fd == 0)
            failRun("cannot open the trace file sim/control_trace.txt");
        else
        begin
            while ($fgets(line, fd) > 0)
            begin
                if (line.len() > 1 && line.getc(0) != "#")
                begin
                    n = $sscanf(line, "%s %h %h %d %s %d %s", nm, op, fn, alu, dst, sp, ev);
                    if (n != 7)
                        failRun({"malformed trace line: ", line});
                    else
                    begin
                        names.push_back(nm);
                        opCodes.push_back(op);
                        funcCodes.push_back(fn);
                        aluOps.push_back(alu);
                        dsts.push_back(dstCode(dst));
                        spacings.push_back(sp);
                        events.push_back(ev);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic runInstruction(input int idx);
        string nm;
        bit    isHalt;
        bit    isLoad;
        bit    isStore;
        bit    isBranch;
        bit    done;
        int    k;
        int    regWrites;
        int    memWrites;
        int    mdrWrites;
        int    wwdPulses;
        int    illegalPulses;
        int    haltedCycles;
        int    condPulses;
        int    ioCycles;
        nm            = names[idx];
        isHalt        = (events[idx] == "halt");
        isLoad        = (opCodes[idx] == cpuControlPkg::LwdOp);
        isStore       = (opCodes[idx] == cpuControlPkg::SwdOp);
        isBranch      = (opCodes[idx] <= cpuControlPkg::BlzOp);
        done          = 1'b0;
        k             = 0;
        regWrites     = 0;
        memWrites     = 0;
        mdrWrites     = 0;
        wwdPulses     = 0;
        illegalPulses = 0;
        haltedCycles  = 0;
        condPulses    = 0;
        ioCycles      = 0;
        @(posedge clk);    // edge that closes the irWrite cycle
        opcode <= cpuControlPkg::opcode_t'(opCodes[idx]);
        func   <= cpuControlPkg::func_t'(funcCodes[idx]);
        while (!done)
        begin
            @(negedge clk);
            k++;
            if (k == 1)
            begin
                checkValue(nm, "pcWrite in decode", 1, pcWrite);
                checkValue(nm, "pcSource in decode", cpuControlPkg::PcIncrement, pcSource);
                checkValue(nm, "aluSrcA in decode", cpuControlPkg::SelPc, aluSrcA);
                checkValue(nm, "aluSrcB in decode", cpuControlPkg::SelOne, aluSrcB);
                checkValue(nm, "immSel in decode", cpuControlPkg::ImmSign, immSel);
            end
            if (k == 2)
                checkValue(nm, "aluOp in execute", aluOps[idx], aluOp);
            if (regWrite)
            begin
                regWrites++;
                if (dsts[idx] < 0)
                    checkValue(nm, "regWrite in writeback", 0, regWrite);
                checkValue(nm, "regDstSel in writeback", dsts[idx], regDstSel);
                checkValue(nm, "memToReg in writeback", isLoad, memToReg);
            end
            memWrites     += memWrite;
            mdrWrites     += mdrWrite;
            wwdPulses     += wwdValid;
            illegalPulses += illegalInstr;
            condPulses    += pcWriteCond;
            ioCycles      += iorD;
            if (isHalt)
            begin
                checkValue(nm, "irWrite after halt", 0, irWrite);
                checkValue(nm, "halted", k > 2, halted);    // halted from the cycle after execute
                if (k > 2)
                    checkValue(nm, "aluSrcB while halted", cpuControlPkg::SelOne, aluSrcB);
                done = (k == 2 + HaltWatch);
            end
            else
            begin
                haltedCycles += halted;
                done = irWrite;
            end
        end
        if (!isHalt)
            checkValue(nm, "irWrite spacing", spacings[idx], k);
        checkValue(nm, "regWrite cycles", (dsts[idx] >= 0) ? 1 : 0, regWrites);
        checkValue(nm, "memWrite cycles", isStore ? MemLatency : 0, memWrites);
        checkValue(nm, "iorD cycles", (isLoad || isStore) ? MemLatency : 0, ioCycles);
        checkValue(nm, "mdrWrite pulses", isLoad ? 1 : 0, mdrWrites);
        checkValue(nm, "pcWriteCond pulses", isBranch ? 1 : 0, condPulses);
        checkValue(nm, "wwdValid pulses", (events[idx] == "wwd") ? 1 : 0, wwdPulses);
        checkValue(nm, "illegalInstr pulses", (events[idx] == "illegal") ? 1 : 0,
                   illegalPulses);
        checkValue(nm, "halted before halt", 0, haltedCycles);
    endtask

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;    // 8 ns
    end

    initial
    begin
        wait (traceLoaded);
        repeat (names.size() * (2 * MemLatency + 4) + HaltWatch + 10) @(posedge clk);
        failRun("timeout: the DUT did not get through the trace in time");
    end

    initial
    begin
        wait (DUT.uProps.assertFails != 0);
        failRun("a bound assertion on the DUT failed");
    end

    initial
    begin
        arstN  = 1'b0;
        opcode = cpuControlPkg::BneOp;
        func   = cpuControlPkg::FnAdd;
        loadTrace();
        traceLoaded = 1'b1;
        repeat (2)
        begin
            @(negedge clk);
            checkValue("reset", "controls during reset", 0, ctlBits);
        end
        @(posedge clk);
        arstN <= 1'b1;
        @(negedge clk);
        checkValue("reset", "controls in idle", 0, ctlBits);
        @(negedge clk);
        checkValue("reset", "memRead in first fetch", 1, memRead);
        while (!irWrite)
            @(negedge clk);
        foreach (names[i])
            runInstruction(i);
        $display("=== PASS ===");
        $finish;
    end

endmodule

// ==== sim/multicycleControl_properties.sv ====
`timescale 1ns/1ps

module multicycleControlProperties (
    input logic clk,
    input logic arstN,
    input logic memRead,
    input logic memWrite,
    input logic irWrite,
    input logic halted
);

    int assertFails = 0;    // failed assertion count

    memExclusive: assert property (@(posedge clk) disable iff (!arstN)
                                   !(memRead && memWrite))
        else
        begin
            assertFails++;
            $error("memRead and memWrite high in the same cycle");
        end

    irNeedsRead: assert property (@(posedge clk) disable iff (!arstN)
                                  irWrite |-> memRead)
        else
        begin
            assertFails++;
            $error("irWrite without memRead");
        end

    haltSticky: assert property (@(posedge clk) disable iff (!arstN)
                                 halted |=> halted)
        else
        begin
            assertFails++;
            $error("halted dropped without reset");
        end

endmodule

bind multicycleControl multicycleControlProperties uProps (
    .clk      (clk),
    .arstN    (arstN),
    .memRead  (memRead),
    .memWrite (memWrite),
    .irWrite  (irWrite),
    .halted   (halted)
);

// ==== src/multicycleControl.sv ====
`timescale 1ns/1ps

module multicycleControl #(
    parameter int MemLatency = 2    // cycles per memory access, 1 to 8
) (
    input  logic                    clk,
    input  logic                    arstN,
    input  cpuControlPkg::opcode_t  opcode,
    input  cpuControlPkg::func_t    func,
    output logic                    pcWrite,
    output logic                    pcWriteCond,
    output logic                    iorD,
    output logic                    memRead,
    output logic                    memWrite,
    output logic                    irWrite,
    output logic                    mdrWrite,
    output logic                    memToReg,
    output logic                    regWrite,
    output logic                    wwdValid,
    output logic                    illegalInstr,
    output logic                    halted,
    output cpuControlPkg::pcSel_t   pcSource,
    output cpuControlPkg::aluFunc_t aluOp,
    output cpuControlPkg::aSel_t    aluSrcA,
    output cpuControlPkg::bSel_t    aluSrcB,
    output cpuControlPkg::immKind_t immSel,
    output cpuControlPkg::regDst_t  regDstSel
);

    cpuControlPkg::instrClass_t instrClass;
    cpuControlPkg::aluFunc_t    execAluOp;
    cpuControlPkg::aSel_t       execSrcA;
    cpuControlPkg::bSel_t       execSrcB;
    cpuControlPkg::immKind_t    immKind;
    cpuControlPkg::regDst_t     regDst;
    cpuControlPkg::phase_t      phase;
    logic                       lastBeat;

    instrDecoder uDecoder (
        .opcode     (opcode),
        .func       (func),
        .instrClass (instrClass),
        .execAluOp  (execAluOp),
        .execSrcA   (execSrcA),
        .execSrcB   (execSrcB),
        .immKind    (immKind),
        .regDst     (regDst)
    );

    phaseSequencer #(
        .MemLatency (MemLatency)
    ) uSequencer (
        .clk        (clk),
        .arstN      (arstN),
        .instrClass (instrClass),
        .phase      (phase),
        .lastBeat   (lastBeat)
    );

    controlEncoder uEncoder (
        .phase        (phase),
        .lastBeat     (lastBeat),
        .instrClass   (instrClass),
        .execAluOp    (execAluOp),
        .execSrcA     (execSrcA),
        .execSrcB     (execSrcB),
        .immKind      (immKind),
        .regDst       (regDst),
        .pcWrite      (pcWrite),
        .pcWriteCond  (pcWriteCond),
        .iorD         (iorD),
        .memRead      (memRead),
        .memWrite     (memWrite),
        .irWrite      (irWrite),
        .mdrWrite     (mdrWrite),
        .memToReg     (memToReg),
        .regWrite     (regWrite),
        .wwdValid     (wwdValid),
        .illegalInstr (illegalInstr),
        .halted       (halted),
        .pcSource     (pcSource),
        .aluOp        (aluOp),
        .aluSrcA      (aluSrcA),
        .aluSrcB      (aluSrcB),
        .immSel       (immSel),
        .regDstSel    (regDstSel)
    );

endmodule

// ==== src/controlEncoder.sv ====
`timescale 1ns/1ps

module controlEncoder (
    input  cpuControlPkg::phase_t      phase,
    input  logic                       lastBeat,
    input  cpuControlPkg::instrClass_t instrClass,
    input  cpuControlPkg::aluFunc_t    execAluOp,
    input  cpuControlPkg::aSel_t       execSrcA,
    input  cpuControlPkg::bSel_t       execSrcB,
    input  cpuControlPkg::immKind_t    immKind,
    input  cpuControlPkg::regDst_t     regDst,
    output logic                       pcWrite,
    output logic                       pcWriteCond,
    output logic                       iorD,
    output logic                       memRead,
    output logic                       memWrite,
    output logic                       irWrite,
    output logic                       mdrWrite,
    output logic                       memToReg,
    output logic                       regWrite,
    output logic                       wwdValid,
    output logic                       illegalInstr,
    output logic                       halted,
    output cpuControlPkg::pcSel_t      pcSource,
    output cpuControlPkg::aluFunc_t    aluOp,
    output cpuControlPkg::aSel_t       aluSrcA,
    output cpuControlPkg::bSel_t       aluSrcB,
    output cpuControlPkg::immKind_t    immSel,
    output cpuControlPkg::regDst_t     regDstSel
);

    logic isLoad;

    assign isLoad = (instrClass == cpuControlPkg::ClsLoad);

    always_comb
    begin
        pcWrite      = 1'b0;
        pcWriteCond  = 1'b0;
        iorD         = 1'b0;
        memRead      = 1'b0;
        memWrite     = 1'b0;
        irWrite      = 1'b0;
        mdrWrite     = 1'b0;
        memToReg     = 1'b0;
        regWrite     = 1'b0;
        wwdValid     = 1'b0;
        illegalInstr = 1'b0;
        halted       = 1'b0;
        pcSource     = cpuControlPkg::PcIncrement;
        aluOp        = cpuControlPkg::AluAdd;
        aluSrcA      = cpuControlPkg::SelPc;
        aluSrcB      = cpuControlPkg::SelOne;    // resting selects: pc + 1
        immSel       = cpuControlPkg::ImmSign;
        regDstSel    = cpuControlPkg::DstRt;

        case (phase)
            cpuControlPkg::PhFetch:
            begin
                memRead = 1'b1;
                irWrite = lastBeat;
            end
            cpuControlPkg::PhDecode:
                pcWrite = 1'b1;    // pc <= pc + 1
            cpuControlPkg::PhExecute:
            begin
                aluOp   = execAluOp;
                aluSrcA = execSrcA;
                aluSrcB = execSrcB;
                immSel  = immKind;
                case (instrClass)
                    cpuControlPkg::ClsBranch:
                    begin
                        pcWriteCond = 1'b1;
                        pcSource    = cpuControlPkg::PcBranchTarget;
                    end
                    cpuControlPkg::ClsJump, cpuControlPkg::ClsJumpLink:
                    begin
                        pcWrite  = 1'b1;
                        pcSource = cpuControlPkg::PcJumpTarget;
                        immSel   = cpuControlPkg::ImmTarget;
                    end
                    cpuControlPkg::ClsJumpReg, cpuControlPkg::ClsJumpRegLink:
                    begin
                        pcWrite  = 1'b1;
                        pcSource = cpuControlPkg::PcRegister;
                    end
                    cpuControlPkg::ClsWwd:
                        wwdValid = 1'b1;
                    cpuControlPkg::ClsIllegal:
                        illegalInstr = 1'b1;
                    default:
                        pcWrite = 1'b0;
                endcase
            end
            cpuControlPkg::PhMemory:
            begin
                iorD     = 1'b1;
                memRead  = isLoad;
                memWrite = (instrClass == cpuControlPkg::ClsStore);
                mdrWrite = isLoad && lastBeat;    // data valid on last beat
            end
            cpuControlPkg::PhWriteback:
            begin
                regWrite  = 1'b1;
                regDstSel = regDst;
                memToReg  = isLoad;
            end
            cpuControlPkg::PhHalted:
                halted = 1'b1;
            default:
                aluSrcB = cpuControlPkg::SelRegB;    // idle, everything low
        endcase
    end

endmodule

// ==== src/phaseSequencer.sv ====
`timescale 1ns/1ps

module phaseSequencer #(
    parameter int MemLatency = 2
) (
    input  logic                       clk,
    input  logic                       arstN,
    input  cpuControlPkg::instrClass_t instrClass,
    output cpuControlPkg::phase_t      phase,
    output logic                       lastBeat
);

    localparam int BeatWidth = (MemLatency > 1) ? $clog2(MemLatency) : 1;
    localparam logic [BeatWidth-1:0] LastCount = BeatWidth'(MemLatency - 1);

    logic [BeatWidth-1:0]  beatCnt;
    logic                  inAccess;
    cpuControlPkg::phase_t nextPhase;

    // fetch and memory share the beat counter
    assign inAccess = (phase == cpuControlPkg::PhFetch) || (phase == cpuControlPkg::PhMemory);
    assign lastBeat = inAccess && (beatCnt == LastCount);

    always_comb
    begin
        nextPhase = phase;
        case (phase)
            cpuControlPkg::PhIdle:
                nextPhase = cpuControlPkg::PhFetch;
            cpuControlPkg::PhFetch:
                if (lastBeat)
                    nextPhase = cpuControlPkg::PhDecode;
            cpuControlPkg::PhDecode:
                nextPhase = cpuControlPkg::PhExecute;
            cpuControlPkg::PhExecute:
            begin
                if (cpuControlPkg::accessesMemory(instrClass))
                    nextPhase = cpuControlPkg::PhMemory;
                else if (cpuControlPkg::writesRegister(instrClass))
                    nextPhase = cpuControlPkg::PhWriteback;
                else if (instrClass == cpuControlPkg::ClsHalt)
                    nextPhase = cpuControlPkg::PhHalted;
                else
                    nextPhase = cpuControlPkg::PhFetch;
            end
            cpuControlPkg::PhMemory:
                if (lastBeat)
                    nextPhase = (instrClass == cpuControlPkg::ClsLoad)
                                ? cpuControlPkg::PhWriteback
                                : cpuControlPkg::PhFetch;
            cpuControlPkg::PhWriteback:
                nextPhase = cpuControlPkg::PhFetch;
            cpuControlPkg::PhHalted:
                nextPhase = cpuControlPkg::PhHalted;    // only reset leaves
            default:
                nextPhase = cpuControlPkg::PhIdle;
        endcase
    end

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            phase   <= cpuControlPkg::PhIdle;
            beatCnt <= '0;
        end
        else
        begin
            phase <= nextPhase;
            if (inAccess && !lastBeat)
                beatCnt <= beatCnt + 1'b1;
            else
                beatCnt <= '0;    // restart for the next access
        end
    end

endmodule

// ==== src/instrDecoder.sv ====
`timescale 1ns/1ps

module instrDecoder (
    input  cpuControlPkg::opcode_t     opcode,
    input  cpuControlPkg::func_t       func,
    output cpuControlPkg::instrClass_t instrClass,
    output cpuControlPkg::aluFunc_t    execAluOp,
    output cpuControlPkg::aSel_t       execSrcA,
    output cpuControlPkg::bSel_t       execSrcB,
    output cpuControlPkg::immKind_t    immKind,
    output cpuControlPkg::regDst_t     regDst
);

    always_comb
    begin
        instrClass = cpuControlPkg::ClsIllegal;    // unknown codes fall through as no-op
        execAluOp  = cpuControlPkg::AluAdd;
        execSrcA   = cpuControlPkg::SelRegA;
        execSrcB   = cpuControlPkg::SelImm;
        immKind    = cpuControlPkg::ImmSign;
        regDst     = cpuControlPkg::DstRt;

        case (opcode)
            cpuControlPkg::BneOp, cpuControlPkg::BeqOp:
            begin
                instrClass = cpuControlPkg::ClsBranch;
                execSrcB   = cpuControlPkg::SelRegB;
                execAluOp  = (opcode == cpuControlPkg::BneOp) ? cpuControlPkg::AluBne
                                                              : cpuControlPkg::AluBeq;
            end
            cpuControlPkg::BgzOp, cpuControlPkg::BlzOp:
            begin
                instrClass = cpuControlPkg::ClsBranch;
                execSrcB   = cpuControlPkg::SelZero;    // compare against zero
                execAluOp  = (opcode == cpuControlPkg::BgzOp) ? cpuControlPkg::AluBgz
                                                              : cpuControlPkg::AluBlz;
            end
            cpuControlPkg::AdiOp:
                instrClass = cpuControlPkg::ClsAluI;
            cpuControlPkg::OriOp:
            begin
                instrClass = cpuControlPkg::ClsAluI;
                execAluOp  = cpuControlPkg::AluOrr;
                immKind    = cpuControlPkg::ImmZero;
            end
            cpuControlPkg::LhiOp:
            begin
                instrClass = cpuControlPkg::ClsAluI;
                execAluOp  = cpuControlPkg::AluLhi;
                immKind    = cpuControlPkg::ImmUpper;
            end
            cpuControlPkg::LwdOp:
                instrClass = cpuControlPkg::ClsLoad;    // address = rs + simm
            cpuControlPkg::SwdOp:
                instrClass = cpuControlPkg::ClsStore;
            cpuControlPkg::JmpOp, cpuControlPkg::JalOp:
            begin
                instrClass = (opcode == cpuControlPkg::JalOp) ? cpuControlPkg::ClsJumpLink
                                                              : cpuControlPkg::ClsJump;
                execSrcA   = cpuControlPkg::SelPc;
                immKind    = cpuControlPkg::ImmTarget;
                regDst     = cpuControlPkg::DstLink;
            end
            cpuControlPkg::AluOp:
            begin
                execSrcB = cpuControlPkg::SelRegB;
                regDst   = cpuControlPkg::DstRd;
                case (func)
                    cpuControlPkg::FnAdd: execAluOp = cpuControlPkg::AluAdd;
                    cpuControlPkg::FnSub: execAluOp = cpuControlPkg::AluSub;
                    cpuControlPkg::FnAnd: execAluOp = cpuControlPkg::AluAnd;
                    cpuControlPkg::FnOrr: execAluOp = cpuControlPkg::AluOrr;
                    cpuControlPkg::FnNot: execAluOp = cpuControlPkg::AluNot;
                    cpuControlPkg::FnTcp: execAluOp = cpuControlPkg::AluTcp;
                    cpuControlPkg::FnShl: execAluOp = cpuControlPkg::AluShl;
                    cpuControlPkg::FnShr: execAluOp = cpuControlPkg::AluShr;
                    default:              execAluOp = cpuControlPkg::AluAdd;
                endcase
                case (func)
                    cpuControlPkg::FnAdd, cpuControlPkg::FnSub, cpuControlPkg::FnAnd,
                    cpuControlPkg::FnOrr, cpuControlPkg::FnNot, cpuControlPkg::FnTcp:
                        instrClass = cpuControlPkg::ClsAluR;
                    cpuControlPkg::FnShl, cpuControlPkg::FnShr:
                    begin
                        instrClass = cpuControlPkg::ClsAluR;
                        execSrcB   = cpuControlPkg::SelOne;    // shift by one
                    end
                    cpuControlPkg::FnJpr, cpuControlPkg::FnJrl:
                    begin
                        instrClass = (func == cpuControlPkg::FnJrl)
                                     ? cpuControlPkg::ClsJumpRegLink
                                     : cpuControlPkg::ClsJumpReg;
                        execSrcB   = cpuControlPkg::SelZero;    // rs passes through
                        regDst     = cpuControlPkg::DstLink;
                    end
                    cpuControlPkg::FnWwd:
                    begin
                        instrClass = cpuControlPkg::ClsWwd;
                        execSrcB   = cpuControlPkg::SelZero;
                    end
                    cpuControlPkg::FnHlt:
                        instrClass = cpuControlPkg::ClsHalt;
                    default:
                        instrClass = cpuControlPkg::ClsIllegal;
                endcase
            end
            default:
            begin
                execSrcA = cpuControlPkg::SelPc;
                execSrcB = cpuControlPkg::SelOne;
            end
        endcase
    end

endmodule

// ==== src/cpuControlPkg.sv ====
package cpuControlPkg;

    typedef enum logic [3:0] {
        BneOp = 4'd0,
        BeqOp = 4'd1,
        BgzOp = 4'd2,
        BlzOp = 4'd3,
        AdiOp = 4'd4,
        OriOp = 4'd5,
        LhiOp = 4'd6,
        LwdOp = 4'd7,
        SwdOp = 4'd8,
        JmpOp = 4'd9,
        JalOp = 4'd10,
        AluOp = 4'd15
    } opcode_t;

    // function field of R-type words (opcode AluOp)
    typedef enum logic [5:0] {
        FnAdd = 6'd0,
        FnSub = 6'd1,
        FnAnd = 6'd2,
        FnOrr = 6'd3,
        FnNot = 6'd4,
        FnTcp = 6'd5,
        FnShl = 6'd6,
        FnShr = 6'd7,
        FnJpr = 6'd25,
        FnJrl = 6'd26,
        FnWwd = 6'd28,
        FnHlt = 6'd29
    } func_t;

    typedef enum logic [3:0] {
        AluAdd, AluSub, AluAnd, AluOrr, AluNot, AluTcp, AluShl, AluShr,
        AluLhi, AluBne, AluBeq, AluBgz, AluBlz
    } aluFunc_t;

    typedef enum logic [3:0] {
        ClsAluR, ClsAluI, ClsLoad, ClsStore, ClsBranch, ClsJump, ClsJumpLink,
        ClsJumpReg, ClsJumpRegLink, ClsWwd, ClsHalt, ClsIllegal
    } instrClass_t;

    typedef enum logic [2:0] {
        PhIdle, PhFetch, PhDecode, PhExecute, PhMemory, PhWriteback, PhHalted
    } phase_t;

    typedef enum logic [1:0] {
        PcIncrement,    // alu result, pc+1
        PcBranchTarget,
        PcJumpTarget,
        PcRegister
    } pcSel_t;

    typedef enum logic {SelPc, SelRegA} aSel_t;

    typedef enum logic [1:0] {SelRegB, SelOne, SelImm, SelZero} bSel_t;

    typedef enum logic [1:0] {ImmSign, ImmZero, ImmUpper, ImmTarget} immKind_t;

    typedef enum logic [1:0] {DstRt, DstRd, DstLink} regDst_t;

    // classes that end with a register file write
    function automatic logic writesRegister(instrClass_t cls);
        return cls inside {ClsAluR, ClsAluI, ClsLoad, ClsJumpLink, ClsJumpRegLink};
    endfunction

    function automatic logic accessesMemory(instrClass_t cls);
        return cls inside {ClsLoad, ClsStore};
    endfunction

endpackage
